//--- sim.f
+incdir+source
source/cube_pkg.sv
source/corner_locator.sv
source/cube_turner.sv
source/corner_planner.sv
source/corner_solver_top.sv
sim/corner_solver_props.sv
sim/corner_solver_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= corner_solver_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_TEXT ?= Result: PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/corner_solver_tb.sv
`timescale 1ns/100ps
`include "cube_macros.svh"

module corner_solver_tb;

    localparam int clock_period = 8;
    localparam int trial_count = 31;
    localparam int moves_per_trial = 400;
    localparam int cycles_per_move = 40;
    localparam int watchdog_ns = trial_count * moves_per_trial * cycles_per_move * clock_period;

    // sticker colour codes
    localparam logic [2:0] col_white = 3'd0;
    localparam logic [2:0] col_orange = 3'd1;
    localparam logic [2:0] col_green = 3'd2;
    localparam logic [2:0] col_red = 3'd3;
    localparam logic [2:0] col_blue = 3'd4;
    localparam logic [2:0] col_yellow = 3'd5;

    logic                    clock;
    logic                    rst_n;
    logic                    load_valid;
    logic [`CUBE_WORD_W-1:0] load_cube;
    logic                    ext_turn_valid;
    logic [`CUBE_MOVE_W-1:0] ext_turn_move;
    logic                    ext_turn_ready;
    logic                    start;
    logic                    busy;
    logic                    solve_done;
    logic                    move_valid;
    logic [`CUBE_MOVE_W-1:0] move_code;
    logic                    move_credit;
    logic [`CUBE_WORD_W-1:0] cube;

    int owed;
    int credit_delay;
    bit fail_reported;
    bit run_passed;

    corner_solver_top corner_solver_top_inst (.*);

    bind corner_solver_top corner_solver_props corner_solver_props_inst (.*);

    function automatic logic [8:0] corner_bits(logic [2:0] ud, logic [2:0] cw1, logic [2:0] cw2);
        return {ud, cw1, cw2};
    endfunction

    // slots 7 down to 4, DRB DLB DRF DLF
    function automatic logic [35:0] solved_bottom();
        return {corner_bits(col_yellow, col_blue, col_red),
                corner_bits(col_yellow, col_orange, col_blue),
                corner_bits(col_yellow, col_red, col_green),
                corner_bits(col_yellow, col_green, col_orange)};
    endfunction

    function automatic logic [71:0] solved_word();
        return {solved_bottom(), {12{col_white}}};
    endfunction

    // mostly short waits, now and then a long executor stall
    function automatic int pick_credit_delay();
        if ($urandom_range(0, 15) == 0) begin
            return 30;
        end
        return int'($urandom_range(0, 6));
    endfunction

    task automatic halt_run(string reason);
        fail_reported = 1'b1;
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(string test_name, logic [71:0] expected, logic [71:0] actual);
        halt_run($sformatf("FAILED %s: expected %h, actual %h", test_name, expected, actual));
    endtask

    task automatic load_solved();
        load_valid = 1'b1;
        load_cube = solved_word();
        @(negedge clock);
        load_valid = 1'b0;
        @(negedge clock);
    endtask

    task automatic offer_turn(logic [`CUBE_MOVE_W-1:0] move);
        ext_turn_valid = 1'b1;
        ext_turn_move = move;
        while (!ext_turn_ready) begin
            @(negedge clock);
        end
        @(negedge clock);
        ext_turn_valid = 1'b0;
    endtask

    task automatic check_reset_state();
        assert (!busy && !solve_done && !move_valid)
            else report_mismatch("reset_flags", 72'd0, 72'({busy, solve_done, move_valid}));
        assert (cube == solved_word())
            else report_mismatch("reset_cube", solved_word(), cube);
    endtask

    task automatic solve_and_check(string test_name, int turns);
        int moves_seen;
        moves_seen = 0;
        load_solved();
        for (int i = 0; i < turns; i++) begin
            offer_turn(4'($urandom_range(0, 11)));
        end
        start = 1'b1;
        @(negedge clock);
        start = 1'b0;
        while (!solve_done) begin
            if (move_valid) begin
                moves_seen++;
            end
            @(negedge clock);
        end
        if (turns == 0) begin
            assert (moves_seen == 0)
                else report_mismatch({test_name, " moves"}, 72'd0, 72'(moves_seen));
        end
        assert (cube[71:36] == solved_bottom())
            else report_mismatch({test_name, " bottom"}, 72'(solved_bottom()), 72'(cube[71:36]));
    endtask

    initial begin
        clock = 1'b0;
        forever begin
            #(clock_period / 2) clock = ~clock;
        end
    end

    initial begin
        #(watchdog_ns);
        halt_run($sformatf("watchdog expired after %0d ns before all %0d trials finished",
                           watchdog_ns, trial_count));
    end

    // executor model, one credit back per finished move
    always @(negedge clock) begin
        move_credit = 1'b0;
        if (rst_n) begin
            if (credit_delay > 0) begin
                credit_delay = credit_delay - 1;
            end else if (owed > 0) begin
                move_credit = 1'b1;
                owed = owed - 1;
                credit_delay = pick_credit_delay();
            end
            if (move_valid) begin
                owed = owed + 1;
            end
        end
    end

    initial begin
        int turns;
        void'($urandom(32'h34c3));
        rst_n = 1'b0;
        load_valid = 1'b0;
        load_cube = '0;
        ext_turn_valid = 1'b0;
        ext_turn_move = '0;
        start = 1'b0;
        move_credit = 1'b0;
        owed = 0;
        credit_delay = 0;
        fail_reported = 1'b0;
        run_passed = 1'b0;
        repeat (8) @(negedge clock);
        rst_n = 1'b1;
        check_reset_state();
        solve_and_check("no_scramble", 0);
        for (int t = 1; t < trial_count; t++) begin
            turns = $urandom_range(1, 20);
            solve_and_check($sformatf("scramble_%0d", t), turns);
        end
        run_passed = 1'b1;
        $display("Result: PASSED");
        $finish;
    end

    // a bound assertion can end the run without passing through halt_run
    final begin
        if (!run_passed && !fail_reported) begin
            $display("Result: FAILED");
        end
    end

endmodule

//--- sim/corner_solver_props.sv
`timescale 1ns/100ps
`include "cube_macros.svh"

module corner_solver_props (
    input logic                    clock,
    input logic                    rst_n,
    input logic                    start,
    input logic                    busy,
    input logic                    solve_done,
    input logic                    ext_turn_ready,
    input logic                    move_valid,
    input logic [`CUBE_MOVE_W-1:0] move_code,
    input logic                    move_credit
);

    // moves handed out and not yet credited back
    int outstanding;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            outstanding <= 0;
        end else if (move_valid && !move_credit) begin
            outstanding <= outstanding + 1;
        end else if (!move_valid && move_credit && outstanding > 0) begin
            outstanding <= outstanding - 1;
        end
    end

    credit_limit: assert property (@(posedge clock) disable iff (!rst_n)
        outstanding <= `CUBE_MOVE_CREDITS)
        else $error("more moves outstanding than the executor can hold");

    no_move_at_limit: assert property (@(posedge clock) disable iff (!rst_n)
        !(move_valid && outstanding == `CUBE_MOVE_CREDITS))
        else $error("move issued with no credit left");

    ready_while_busy: assert property (@(posedge clock) disable iff (!rst_n)
        !(ext_turn_ready && busy))
        else $error("external turn accepted while the solver was busy");

    move_code_range: assert property (@(posedge clock) disable iff (!rst_n)
        move_valid |-> move_code < 4'd12)
        else $error("move code outside the twelve face turns");

    done_busy_apart: assert property (@(posedge clock) disable iff (!rst_n)
        !(solve_done && busy))
        else $error("solve_done and busy high together");

    start_raises_busy: assert property (@(posedge clock) disable iff (!rst_n)
        (start && !busy) |=> busy)
        else $error("start while idle did not raise busy");

endmodule

//--- source/corner_solver_top.sv
`timescale 1ns/100ps
`include "cube_macros.svh"

module corner_solver_top (
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    load_valid,
    input  logic [`CUBE_WORD_W-1:0] load_cube,
    input  logic                    ext_turn_valid,
    input  logic [`CUBE_MOVE_W-1:0] ext_turn_move,
    output logic                    ext_turn_ready,
    input  logic                    start,
    output logic                    busy,
    output logic                    solve_done,
    output logic                    move_valid,
    output logic [`CUBE_MOVE_W-1:0] move_code,
    input  logic                    move_credit,
    output logic [`CUBE_WORD_W-1:0] cube
);
    import cube_pkg::*;

    cube_u      cube_word;
    cube_u      load_word;
    move_t      ext_move;
    move_t      turn_move;
    move_t      move_out;
    logic       turn_valid;
    logic [1:0] step;
    slot_t      found_slot;
    twist_t     found_twist;
    logic       in_place;

    assign load_word = load_cube;
    assign ext_move = move_t'(ext_turn_move);
    assign cube = cube_word;
    assign move_code = move_out;

    corner_locator corner_locator_inst (
        .cube        (cube_word),
        .step        (step),
        .found_slot  (found_slot),
        .found_twist (found_twist),
        .in_place    (in_place)
    );

    cube_turner cube_turner_inst (
        .clock          (clock),
        .rst_n          (rst_n),
        .load_valid     (load_valid),
        .load_cube      (load_word),
        .ext_turn_valid (ext_turn_valid),
        .ext_turn_move  (ext_move),
        .ext_turn_ready (ext_turn_ready),
        .busy           (busy),
        .turn_valid     (turn_valid),
        .turn_move      (turn_move),
        .cube           (cube_word)
    );

    corner_planner corner_planner_inst (
        .clock       (clock),
        .rst_n       (rst_n),
        .start       (start),
        .cube        (cube_word),
        .found_slot  (found_slot),
        .found_twist (found_twist),
        .in_place    (in_place),
        .step        (step),
        .busy        (busy),
        .solve_done  (solve_done),
        .turn_valid  (turn_valid),
        .turn_move   (turn_move),
        .move_valid  (move_valid),
        .move_code   (move_out),
        .move_credit (move_credit)
    );

endmodule

//--- source/corner_planner.sv
`timescale 1ns/100ps
`include "cube_macros.svh"

module corner_planner (
    input  logic             clock,
    input  logic             rst_n,
    input  logic             start,
    input  cube_pkg::cube_u  cube,
    input  cube_pkg::slot_t  found_slot,
    input  cube_pkg::twist_t found_twist,
    input  logic             in_place,
    output logic [1:0]       step,
    output logic             busy,
    output logic             solve_done,
    output logic             turn_valid,
    output cube_pkg::move_t  turn_move,
    output logic             move_valid,
    output cube_pkg::move_t  move_code,
    input  logic             move_credit
);
    import cube_pkg::*;

    localparam int credit_w = $clog2(`CUBE_MOVE_CREDITS + 1);
    localparam int pos_w = $clog2(`CUBE_TRIGGER_LEN);
    localparam logic [credit_w-1:0] credit_max = credit_w'(`CUBE_MOVE_CREDITS);
    localparam logic [pos_w-1:0] last_pos = pos_w'(`CUBE_TRIGGER_LEN - 1);

    typedef enum logic [1:0] {
        st_idle,
        st_choose,
        st_trigger,
        st_done
    } state_t;

    state_t              state;
    slot_t               trig_slot;
    logic [pos_w-1:0]    trig_pos;
    logic [credit_w-1:0] credits;
    logic                can_move;
    logic                issue;
    logic                lost;
    logic                top_move;
    logic                bottom_solved;
    slot_t               lift_slot;
    move_t               next_move;

    // face, U, face inverse, Ui
    function automatic move_t trigger_move(slot_t slot, logic [pos_w-1:0] pos);
        move_t face;
        face = trigger_face(slot);
        case (pos)
            2'd0: trigger_move = face;
            2'd1: trigger_move = move_u;
            2'd2: trigger_move = move_t'({face[3:1], 1'b1});
            default: trigger_move = move_ui;
        endcase
    endfunction

    assign can_move = (credits != '0);
    assign lost = (found_twist == twist_none);
    assign lift_slot = found_slot[2] ? found_slot : target_slot(step);
    // on top but not yet over its slot
    assign top_move = !found_slot[2] && (found_slot != top_above(target_slot(step)));

    // D face stickers all yellow
    always_comb begin
        bottom_solved = 1'b1;
        for (int s = 4; s < 8; s++) begin
            if (cube.stickers[3 * s + 2] != yellow) begin
                bottom_solved = 1'b0;
            end
        end
    end

    always_comb begin
        issue = 1'b0;
        next_move = move_u;
        case (state)
            st_choose: begin
                if (!in_place && !lost) begin
                    issue = can_move;
                    next_move = top_move ? move_u : trigger_move(lift_slot, '0);
                end
            end
            st_trigger: begin
                issue = can_move;
                next_move = trigger_move(trig_slot, trig_pos);
            end
            default: ;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            step <= 2'd0;
            trig_slot <= '0;
            trig_pos <= '0;
        end else begin
            case (state)
                st_choose: begin
                    if (lost) begin
                        state <= st_done;
                    end else if (in_place) begin
                        if (step != 2'd3) begin
                            step <= step + 2'd1;
                        end else if (bottom_solved) begin
                            state <= st_done;
                        end else begin
                            step <= 2'd0;
                        end
                    end else if (issue && !top_move) begin
                        state <= st_trigger;
                        trig_slot <= lift_slot;
                        trig_pos <= pos_w'(1);
                    end
                end
                st_trigger: begin
                    if (issue) begin
                        if (trig_pos == last_pos) begin
                            state <= st_choose;
                            trig_pos <= '0;
                        end else begin
                            trig_pos <= trig_pos + 1'b1;
                        end
                    end
                end
                default: begin
                    if (start) begin
                        state <= st_choose;
                        step <= 2'd0;
                    end
                end
            endcase
        end
    end

    // extra credit pulses beyond the limit are dropped
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            credits <= credit_max;
        end else if (issue && !move_credit) begin
            credits <= credits - 1'b1;
        end else if (!issue && move_credit && credits < credit_max) begin
            credits <= credits + 1'b1;
        end
    end

    assign busy = (state == st_choose) || (state == st_trigger);
    assign solve_done = (state == st_done);
    assign turn_valid = issue;
    assign move_valid = issue;
    assign turn_move = next_move;
    assign move_code = next_move;

endmodule

//--- source/cube_turner.sv
`timescale 1ns/100ps

module cube_turner (
    input  logic             clock,
    input  logic             rst_n,
    input  logic             load_valid,
    input  cube_pkg::cube_u  load_cube,
    input  logic             ext_turn_valid,
    input  cube_pkg::move_t  ext_turn_move,
    output logic             ext_turn_ready,
    input  logic             busy,
    input  logic             turn_valid,
    input  cube_pkg::move_t  turn_move,
    output cube_pkg::cube_u  cube
);
    import cube_pkg::*;

    logic  apply_turn;
    move_t sel_move;

    // planner owns the cube while solving, load beats external turn
    assign ext_turn_ready = !busy && !load_valid;

    assign apply_turn = busy ? turn_valid : (ext_turn_valid && ext_turn_ready);
    assign sel_move = busy ? turn_move : ext_turn_move;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            cube <= solved_cube();
        end else if (apply_turn) begin
            cube <= turn_cube(sel_move, cube);
        end else if (load_valid && !busy) begin
            cube <= load_cube;
        end
    end

endmodule

//--- source/corner_locator.sv
`timescale 1ns/100ps

module corner_locator (
    input  cube_pkg::cube_u  cube,
    input  logic [1:0]       step,
    output cube_pkg::slot_t  found_slot,
    output cube_pkg::twist_t found_twist,
    output logic             in_place
);
    import cube_pkg::*;

    corner_t target;

    // search all slots under every rotation of the wanted corner
    always_comb begin
        target = target_corner(step);
        found_slot = '0;
        found_twist = twist_none;
        for (int s = 0; s < 8; s++) begin
            for (int k = 0; k < 3; k++) begin
                if (cube.corners[s] == rotate_corner(target, twist_t'(k))) begin
                    found_slot = slot_t'(s);
                    found_twist = twist_t'(k);
                end
            end
        end
    end

    assign in_place = (found_slot == target_slot(step)) && (found_twist == 2'd0);

endmodule

//--- source/cube_pkg.sv
`include "cube_macros.svh"

package cube_pkg;

    typedef enum logic [`CUBE_COLOR_W-1:0] {
        white = 3'd0, orange = 3'd1, green = 3'd2,
        red = 3'd3, blue = 3'd4, yellow = 3'd5
    } color_t;

    // suffix i is counter-clockwise, face code is move[3:1]
    typedef enum logic [`CUBE_MOVE_W-1:0] {
        move_r = 4'd0, move_ri = 4'd1, move_u = 4'd2, move_ui = 4'd3,
        move_f = 4'd4, move_fi = 4'd5, move_l = 4'd6, move_li = 4'd7,
        move_b = 4'd8, move_bi = 4'd9, move_d = 4'd10, move_di = 4'd11
    } move_t;

    // up-or-down sticker first, then the other two in turn order
    typedef struct packed {
        color_t ud;
        color_t cw1;
        color_t cw2;
    } corner_t;

    // slots 0..3 ULB ULF URF URB, slots 4..7 DLF DRF DLB DRB
    typedef union packed {
        color_t  [23:0] stickers;
        corner_t [7:0]  corners;
    } cube_u;

    typedef logic [2:0] slot_t;
    typedef logic [1:0] twist_t;

    // target corner absent from the cube
    localparam twist_t twist_none = 2'd3;

    function automatic corner_t target_corner(logic [1:0] step);
        case (step)
            2'd0: target_corner = '{ud: yellow, cw1: green, cw2: orange};
            2'd1: target_corner = '{ud: yellow, cw1: red, cw2: green};
            2'd2: target_corner = '{ud: yellow, cw1: orange, cw2: blue};
            default: target_corner = '{ud: yellow, cw1: blue, cw2: red};
        endcase
    endfunction

    function automatic slot_t target_slot(logic [1:0] step);
        target_slot = slot_t'({1'b1, step});
    endfunction

    function automatic move_t trigger_face(slot_t slot);
        case (slot)
            3'd4: trigger_face = move_f;
            3'd5: trigger_face = move_r;
            3'd6: trigger_face = move_l;
            default: trigger_face = move_b;
        endcase
    endfunction

    function automatic slot_t top_above(slot_t slot);
        case (slot)
            3'd4: top_above = 3'd1;
            3'd5: top_above = 3'd2;
            3'd6: top_above = 3'd0;
            default: top_above = 3'd3;
        endcase
    endfunction

    // yellow of a twist-0 corner ends up in position k
    function automatic corner_t rotate_corner(corner_t c, twist_t k);
        case (k)
            2'd1: rotate_corner = '{ud: c.cw2, cw1: c.ud, cw2: c.cw1};
            2'd2: rotate_corner = '{ud: c.cw1, cw1: c.cw2, cw2: c.ud};
            default: rotate_corner = c;
        endcase
    endfunction

    // one clockwise quarter turn, face order R U F L B D
    function automatic cube_u turn_cw(logic [2:0] face, cube_u c);
        slot_t cyc [4];
        logic  twists;
        cube_u r;
        r = c;
        twists = 1'b1;
        case (face)
            3'd0: cyc = '{3'd2, 3'd3, 3'd7, 3'd5};
            3'd1: begin
                cyc = '{3'd2, 3'd1, 3'd0, 3'd3};
                twists = 1'b0;
            end
            3'd2: cyc = '{3'd1, 3'd2, 3'd5, 3'd4};
            3'd3: cyc = '{3'd0, 3'd1, 3'd4, 3'd6};
            3'd4: cyc = '{3'd3, 3'd0, 3'd6, 3'd7};
            3'd5: begin
                cyc = '{3'd4, 3'd5, 3'd7, 3'd6};
                twists = 1'b0;
            end
            default: begin
                cyc = '{3'd0, 3'd0, 3'd0, 3'd0};
                twists = 1'b0;
            end
        endcase
        for (int i = 0; i < 4; i++) begin
            twist_t k;
            k = twists ? ((i % 2 == 0) ? 2'd2 : 2'd1) : 2'd0;
            r.corners[cyc[(i + 1) % 4]] = rotate_corner(c.corners[cyc[i]], k);
        end
        return r;
    endfunction

    // inverse turn is three clockwise turns
    function automatic cube_u turn_cube(move_t m, cube_u c);
        cube_u r;
        r = turn_cw(m[3:1], c);
        if (m[0]) begin
            r = turn_cw(m[3:1], turn_cw(m[3:1], r));
        end
        return r;
    endfunction

    function automatic cube_u solved_cube();
        cube_u c;
        for (int s = 0; s < 4; s++) begin
            c.corners[s] = '{ud: white, cw1: white, cw2: white};
        end
        for (int n = 0; n < 4; n++) begin
            c.corners[target_slot(2'(n))] = target_corner(2'(n));
        end
        return c;
    endfunction

endpackage

//--- source/cube_macros.svh
`ifndef CUBE_MACROS_SVH
`define CUBE_MACROS_SVH

// one sticker colour
`define CUBE_COLOR_W 3

// eight corners of three stickers
`define CUBE_WORD_W 72

// face turn code
`define CUBE_MOVE_W 4

// moves the downstream executor can hold at once
`define CUBE_MOVE_CREDITS 4

// face, U, face inverse, Ui
`define CUBE_TRIGGER_LEN 4

`endif
